/* flist.f */
src/plot_geom_pkg.sv
src/sdram_cmd_pkg.sv
src/plot_link_if.sv
src/sample_decode.sv
src/draw_execute.sv
src/extrema_result.sv
src/trend_plot_top.sv
bench/sdram_burst_model.sv
bench/trend_plot_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the trend plot testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module trend_plot_tb -Mdir "$OBJ" -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtrend_plot_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* bench/trend_cases.txt */
# name  pause  gain_code(hex)  sample(hex)  disp_count(hex)
# A pause of 1 means the sample must be ignored.
first_gain1   0 01 000c 000100
full_scale    0 00 00ff 00a0b0
half_gain     0 02 0013 123456
paused_a      1 02 0040 ffffff
quarter_gain  0 03 0021 000001
eighth_gain   0 04 0079 7f0000
odd_gain      0 09 0009 0000ff
ring_fill_6   0 02 0020 00ff00
ring_fill_7   0 00 0010 345678
paused_b      1 00 0008 000000
ring_wrap     0 03 003f 00beef
overwrite_1   0 04 0100 fedcba
cap_exact     0 00 0010 010203
zero_sample   0 02 0000 800000
top_code      0 ff 0007 000010
last_row      0 04 ffff 000002

/* bench/trend_plot_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module trend_plot_tb import plot_geom_pkg::*; ();

    localparam int NUM_POINTS   = 8;
    localparam int PLOT_WIDTH   = 16;
    localparam int LINE_STRIDE  = 480;
    localparam int RING_BASE    = 384000;
    localparam int PLOT_BASE    = 7212;
    localparam int GROUPS       = PLOT_WIDTH / 4;  // Bursts per row.
    localparam int MAX_DELAY    = 4;               // Worst done delay.
    localparam int ACCESS_BOUND = MAX_DELAY + 3;   // Req rise, wait, req drop.
    localparam int INIT_WRITES  = NUM_POINTS * (1 + GROUPS);
    localparam int FRAME_WRITES = 1 + NUM_POINTS * GROUPS;
    localparam int FRAME_BOUND  = (FRAME_WRITES + NUM_POINTS) * ACCESS_BOUND + NUM_POINTS + 8;
    localparam int QUIET_CYCLES = 60;              // Window for paused samples.
    localparam int MAX_CASES    = 64;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        pause;
    logic        sample_valid;
    logic [15:0] sample;
    logic [23:0] disp_count;
    logic [7:0]  gain_code;
    logic        rd_req;
    logic [23:0] rd_addr;
    logic [15:0] rd_data1, rd_data2, rd_data3, rd_data4;
    logic        rd_done;
    logic        wr_req;
    logic [23:0] wr_addr;
    logic [15:0] wr_data1, wr_data2, wr_data3, wr_data4;
    logic        wr_done;
    logic [31:0] max_count;
    logic [31:0] min_count;
    logic        frame_done;

    // Shadow of the ring and the frame geometry.
    logic [15:0] ring_sample [NUM_POINTS];
    logic [23:0] ring_disp   [NUM_POINTS];
    int          read_start;  // Oldest slot of the last frame.
    int          frame_shift; // Gain shift of the last frame.

    string       case_name   [MAX_CASES];
    logic        case_pause  [MAX_CASES];
    logic [7:0]  case_gain   [MAX_CASES];
    logic [15:0] case_sample [MAX_CASES];
    logic [23:0] case_disp   [MAX_CASES];
    int          n_cases;
    int          n_ok;
    int          n_bad;
    int          write_count = 0; // Completed write bursts.
    logic        watch_armed = 1'b0;
    int          watch_cycles;

    trend_plot_top #(
        .NUM_POINTS  (NUM_POINTS),
        .PLOT_WIDTH  (PLOT_WIDTH),
        .LINE_STRIDE (LINE_STRIDE),
        .RING_BASE   (RING_BASE),
        .PLOT_BASE   (PLOT_BASE)
    ) u_trend_plot_top (.*);

    sdram_burst_model #(.MAX_DELAY(MAX_DELAY)) u_memory (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) if (wr_done) write_count <= write_count + 1;

    ////////////////////
    // Expected values.
    ////////////////////
    function automatic int gain_to_shift(input logic [7:0] code);
        case (code)
            8'd2:    return 1;
            8'd3:    return 2;
            8'd4:    return 3;
            default: return 0; // No division.
        endcase
    endfunction

    function automatic logic [15:0] mem_word(input int addr);
        return u_memory.mem[19'(addr)];
    endfunction

    task automatic compare(input string test, input string what, input logic [31:0] exp,
                           input logic [31:0] act, inout int errs);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h actual %h", test, what, exp, act);
            errs++;
        end
    endtask

    task automatic check_ring(input string test, inout int errs);
        logic [15:0] exp_w [4];
        int          addr;
        for (int k = 0; k < NUM_POINTS; k++) begin
            addr     = RING_BASE + 4 * k;
            exp_w[0] = ring_sample[k];
            exp_w[1] = {8'h00, ring_disp[k][23:16]}; // High byte first.
            exp_w[2] = {8'h00, ring_disp[k][15:8]};
            exp_w[3] = {8'h00, ring_disp[k][7:0]};
            for (int w = 0; w < 4; w++) begin
                compare(test, $sformatf("slot %0d word %0d", k, w + 1),
                        32'(exp_w[w]), 32'(mem_word(addr + w)), errs);
            end
        end
    endtask

    // Row r holds the bar of the r-th oldest slot.
    task automatic check_plot(input string test, inout int errs);
        int          slot;
        int          len;
        int          addr;
        logic [15:0] exp;
        for (int r = 0; r < NUM_POINTS; r++) begin
            slot = (read_start + r) % NUM_POINTS;
            len  = int'(ring_sample[slot]) >> frame_shift;
            if (len > PLOT_WIDTH) len = PLOT_WIDTH; // Cap at plot width.
            for (int g = 0; g < GROUPS; g++) begin
                exp = (4 * g + 4 <= len) ? color_bar_c : color_bg_c;
                for (int w = 0; w < 4; w++) begin
                    addr = PLOT_BASE + r * LINE_STRIDE + 4 * g + w;
                    compare(test, $sformatf("row %0d pixel %0d", r, 4 * g + w),
                            32'(exp), 32'(mem_word(addr)), errs);
                end
            end
        end
    endtask

    task automatic check_extrema(input string test, inout int errs);
        logic [23:0] hi;
        logic [23:0] lo;
        hi = '0;
        lo = '1;
        for (int k = 0; k < NUM_POINTS; k++) begin
            if (ring_disp[k] > hi) hi = ring_disp[k];
            if (ring_disp[k] < lo) lo = ring_disp[k];
        end
        compare(test, "max_count", {8'h00, hi}, max_count, errs);
        compare(test, "min_count", {8'h00, lo}, min_count, errs);
    endtask

    task automatic report(input string test, input int errs);
        if (errs == 0) begin
            n_ok++;
            $display("[OK]   %s", test);
        end else begin
            n_bad++;
            $display("[FAIL] %s, %0d mismatches", test, errs);
        end
    endtask

    ////////////////////
    // One case.
    ////////////////////
    task automatic run_case(input int i);
        int    errs;
        int    start_writes;
        logic  busy;
        string nm;
        errs         = 0;
        busy         = 1'b0;
        nm           = case_name[i];
        start_writes = write_count;
        pause        = case_pause[i];
        gain_code    = case_gain[i];
        sample       = case_sample[i];
        disp_count   = case_disp[i];
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        pause        = 1'b0;
        if (case_pause[i]) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (frame_done || rd_req || wr_req) busy = 1'b1;
            end
            if (busy) begin
                $display("%s: SDRAM traffic or a frame started while paused", nm);
                errs++;
            end
        end else begin
            // New sample lands just before the advanced read start.
            ring_sample[read_start] = case_sample[i];
            ring_disp[read_start]   = case_disp[i];
            read_start  = (read_start + 1) % NUM_POINTS;
            frame_shift = gain_to_shift(case_gain[i]);
            while (frame_done !== 1'b1) @(negedge clk);
            compare(nm, "frame writes", 32'(FRAME_WRITES),
                    32'(write_count - start_writes), errs);
            check_extrema(nm, errs);
        end
        check_ring(nm, errs);
        check_plot(nm, errs);
        report(nm, errs);
        @(negedge clk);
    endtask

    ////////////////////
    // Main sequence.
    ////////////////////
    initial begin
        int    fd;
        int    code;
        int    p, g, s, d;
        int    errs;
        string line;
        string nm;
        void'($urandom(12226));
        rst_n        = 1'b0;
        en           = 1'b0;
        pause        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        disp_count   = '0;
        gain_code    = '0;
        n_cases      = 0;
        n_ok         = 0;
        n_bad        = 0;
        read_start   = 0;
        frame_shift  = 0;
        for (int k = 0; k < NUM_POINTS; k++) begin
            ring_sample[k] = '0;
            ring_disp[k]   = '0;
        end

        fd = $fopen("bench/trend_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/trend_cases.txt");
            n_bad++;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin // Skip comments and blanks.
                    if ($sscanf(line, "%s %d %h %h %h", nm, p, g, s, d) == 5) begin
                        case_name[n_cases]   = nm;
                        case_pause[n_cases]  = p[0];
                        case_gain[n_cases]   = 8'(g);
                        case_sample[n_cases] = 16'(s);
                        case_disp[n_cases]   = 24'(d);
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            $display("no usable cases in bench/trend_cases.txt");
            n_bad++;
        end
        watch_cycles = 28 + INIT_WRITES * ACCESS_BOUND
                     + n_cases * (FRAME_BOUND + QUIET_CYCLES + 4);
        watch_armed  = 1'b1;

        repeat (8) @(negedge clk);
        errs = 0;
        compare("reset", "max_count", 32'h0, max_count, errs);
        compare("reset", "min_count", 32'hFFFF_FFFF, min_count, errs);
        compare("reset", "req and done", 32'h0, {29'h0, rd_req, wr_req, frame_done}, errs);
        report("reset", errs);
        rst_n = 1'b1;
        en    = 1'b1;

        // Init clears every slot and every plot group.
        while (write_count < INIT_WRITES) @(negedge clk);
        repeat (4) @(negedge clk);
        errs = 0;
        check_ring("init", errs);
        check_plot("init", errs);
        report("init", errs);

        for (int i = 0; i < n_cases; i++) run_case(i);

        $display("Summary: %0d tests run, %0d clean, %0d with errors", n_ok + n_bad, n_ok, n_bad);
        if (n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, sized from the worst frame length.
    initial begin
        wait (watch_armed);
        repeat (watch_cycles) @(posedge clk);
        $display("watchdog expired, the DUT stopped finishing frames");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/sdram_burst_model.sv */
`timescale 1ns/100ps
`default_nettype none

module sdram_burst_model #(
    parameter int ADDR_W    = 19, // Modelled word address bits.
    parameter int MAX_DELAY = 4   // Worst done delay in cycles.
) (
    input  logic        clk,
    input  logic        rd_req,
    input  logic [23:0] rd_addr,
    output logic [15:0] rd_data1,
    output logic [15:0] rd_data2,
    output logic [15:0] rd_data3,
    output logic [15:0] rd_data4,
    output logic        rd_done,
    input  logic        wr_req,
    input  logic [23:0] wr_addr,
    input  logic [15:0] wr_data1,
    input  logic [15:0] wr_data2,
    input  logic [15:0] wr_data3,
    input  logic [15:0] wr_data4,
    output logic        wr_done
);

    logic [15:0] mem [0:(1 << ADDR_W) - 1];
    int          rd_wait = 0; // Cycles left before rd_done.
    int          wr_wait = 0;

    function automatic logic [ADDR_W-1:0] word_index(input logic [23:0] base, input int ofs);
        return ADDR_W'(base + 24'(ofs));
    endfunction

    // Fill that differs per address, so a missed write shows up.
    initial begin
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = 16'(a) ^ 16'(a >> 3) ^ 16'h5A5A;
        end
        rd_done  = 1'b0;
        wr_done  = 1'b0;
        rd_data1 = '0;
        rd_data2 = '0;
        rd_data3 = '0;
        rd_data4 = '0;
    end

    ////////////////////
    // Read port.
    ////////////////////
    always @(posedge clk) begin
        rd_done <= 1'b0;
        if (rd_wait > 1) begin
            rd_wait <= rd_wait - 1;
        end else if (rd_wait == 1) begin
            rd_wait  <= 0;
            rd_done  <= 1'b1;
            rd_data1 <= mem[word_index(rd_addr, 0)];
            rd_data2 <= mem[word_index(rd_addr, 1)];
            rd_data3 <= mem[word_index(rd_addr, 2)];
            rd_data4 <= mem[word_index(rd_addr, 3)];
        end else if (rd_req && !rd_done) begin // Req still high on the done edge.
            rd_wait <= 1 + int'($urandom % MAX_DELAY);
        end
    end

    ////////////////////
    // Write port.
    ////////////////////
    always @(posedge clk) begin
        wr_done <= 1'b0;
        if (wr_wait > 1) begin
            wr_wait <= wr_wait - 1;
        end else if (wr_wait == 1) begin
            wr_wait <= 0;
            wr_done <= 1'b1;
            mem[word_index(wr_addr, 0)] = wr_data1; // Burst lands with done.
            mem[word_index(wr_addr, 1)] = wr_data2;
            mem[word_index(wr_addr, 2)] = wr_data3;
            mem[word_index(wr_addr, 3)] = wr_data4;
        end else if (wr_req && !wr_done) begin
            wr_wait <= 1 + int'($urandom % MAX_DELAY);
        end
    end

endmodule

`default_nettype wire

/* src/trend_plot_top.sv */
`timescale 1ns/100ps
`default_nettype none

module trend_plot_top import sdram_cmd_pkg::*; #(
    parameter int NUM_POINTS  = 600,    // Ring slots and plot rows.
    parameter int PLOT_WIDTH  = 216,    // Bar pixels per row.
    parameter int LINE_STRIDE = 480,    // Words per screen line.
    parameter int RING_BASE   = 384000, // First ring slot.
    parameter int PLOT_BASE   = 7212    // First plot pixel.
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        pause,
    input  logic        sample_valid,
    input  logic [15:0] sample,
    input  logic [23:0] disp_count,
    input  logic [7:0]  gain_code,
    // SDRAM read side.
    output logic        rd_req,
    output logic [23:0] rd_addr,
    input  logic [15:0] rd_data1,
    input  logic [15:0] rd_data2,
    input  logic [15:0] rd_data3,
    input  logic [15:0] rd_data4,
    input  logic        rd_done,
    // SDRAM write side.
    output logic        wr_req,
    output logic [23:0] wr_addr,
    output logic [15:0] wr_data1,
    output logic [15:0] wr_data2,
    output logic [15:0] wr_data3,
    output logic [15:0] wr_data4,
    input  logic        wr_done,
    // Results.
    output logic [31:0] max_count,
    output logic [31:0] min_count,
    output logic        frame_done
);

    burst_t rd_burst;
    burst_t wr_burst;

    plot_link_if sample_link ();
    plot_link_if ext_link ();

    assign rd_burst = {rd_data4, rd_data3, rd_data2, rd_data1}; // Word 1 lowest.
    assign wr_data1 = wr_burst[0];
    assign wr_data2 = wr_burst[1];
    assign wr_data3 = wr_burst[2];
    assign wr_data4 = wr_burst[3];

    sample_decode u_sample_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pause        (pause),
        .sample_valid (sample_valid),
        .sample       (sample),
        .disp_count   (disp_count),
        .gain_code    (gain_code),
        .link         (sample_link.sample)
    );

    draw_execute #(
        .NUM_POINTS  (NUM_POINTS),
        .PLOT_WIDTH  (PLOT_WIDTH),
        .LINE_STRIDE (LINE_STRIDE),
        .RING_BASE   (RING_BASE),
        .PLOT_BASE   (PLOT_BASE)
    ) u_draw_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .link       (sample_link.exec),
        .ext        (ext_link.extrema),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_burst),
        .rd_done    (rd_done),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_burst),
        .wr_done    (wr_done),
        .frame_done (frame_done)
    );

    extrema_result u_extrema_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .ext       (ext_link.result),
        .max_count (max_count),
        .min_count (min_count)
    );

endmodule

`default_nettype wire

/* src/extrema_result.sv */
`timescale 1ns/100ps
`default_nettype none

module extrema_result (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    plot_link_if.result ext,
    output logic [31:0] max_count,
    output logic [31:0] min_count
);

    logic [23:0] run_max; // Largest so far this frame.
    logic [23:0] run_min; // Smallest so far this frame.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_max   <= '0;
            run_min   <= '1;
            max_count <= '0;
            min_count <= '1;
        end else if (!en) begin
            run_max   <= '0;
            run_min   <= '1;
            max_count <= '0;
            min_count <= '1;
        end else begin
            if (ext.frame_start) begin
                run_max <= '0;
                run_min <= '1; // Any real value is lower.
            end else if (ext.value_valid) begin
                if (ext.value > run_max) run_max <= ext.value;
                if (ext.value < run_min) run_min <= ext.value;
            end
            // Publish, zero-extended.
            if (ext.frame_end) begin
                max_count <= {8'h00, run_max};
                min_count <= {8'h00, run_min};
            end
        end
    end

endmodule

`default_nettype wire

/* src/draw_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module draw_execute import plot_geom_pkg::*, sdram_cmd_pkg::*; #(
    parameter int NUM_POINTS  = 600,
    parameter int PLOT_WIDTH  = 216,
    parameter int LINE_STRIDE = 480,
    parameter int RING_BASE   = 384000,
    parameter int PLOT_BASE   = 7212
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,
    plot_link_if.exec    link,
    plot_link_if.extrema ext,
    output logic         rd_req,
    output sdram_addr_t  rd_addr,
    input  burst_t       rd_data,
    input  logic         rd_done,
    output logic         wr_req,
    output sdram_addr_t  wr_addr,
    output burst_t       wr_data,
    input  logic         wr_done,
    output logic         frame_done
);

    localparam int GROUPS = PLOT_WIDTH / burst_words_c; // Bursts per row.
    localparam int SLOT_W = (NUM_POINTS > 1) ? $clog2(NUM_POINTS) : 1;
    localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1;
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_POINTS - 1);
    localparam logic [GRP_W-1:0]  LAST_GRP  = GRP_W'(GROUPS - 1);
    localparam sdram_addr_t RING_FIRST = sdram_addr_t'(RING_BASE);
    localparam sdram_addr_t RING_LAST  = sdram_addr_t'(RING_BASE + 4 * (NUM_POINTS - 1));
    localparam sdram_addr_t PLOT_FIRST = sdram_addr_t'(PLOT_BASE);
    localparam sdram_addr_t PLOT_LAST  =
        sdram_addr_t'(PLOT_BASE + (NUM_POINTS - 1) * LINE_STRIDE + PLOT_WIDTH - 4);

    draw_state_e       state;
    logic [SLOT_W-1:0] slot_idx;  // Slot being cleared or read.
    logic [SLOT_W-1:0] rd_start;  // Oldest slot of the frame.
    logic [SLOT_W-1:0] row;
    logic [GRP_W-1:0]  grp;
    sdram_addr_t       row_base;  // First pixel of current row.
    gain_shift_t       frame_shift;
    logic [15:0]       bar_len;   // Capped bar length in pixels.
    logic [15:0]       scaled_len;
    logic [16:0]       grp_end;
    sdram_addr_t       grp_addr;

    function automatic sdram_addr_t slot_addr(input logic [SLOT_W-1:0] idx);
        slot_addr = RING_FIRST + sdram_addr_t'(idx) * sdram_addr_t'(burst_words_c);
    endfunction

    // Ring index step with wrap.
    function automatic logic [SLOT_W-1:0] next_slot(input logic [SLOT_W-1:0] idx);
        next_slot = (idx == LAST_SLOT) ? '0 : idx + 1'b1;
    endfunction

    assign grp_addr   = row_base + sdram_addr_t'(grp) * sdram_addr_t'(burst_words_c);
    assign grp_end    = (17'(grp) + 17'd1) * 17'(burst_words_c); // One past last pixel.
    assign scaled_len = rd_data[0] >> frame_shift;

    assign link.take       = (state == idle) && link.pending;
    assign ext.frame_start = (state == advance);
    assign ext.value_valid = (state == read_slot) && rd_done;
    assign ext.value       = {rd_data[1][7:0], rd_data[2][7:0], rd_data[3][7:0]};
    assign ext.frame_end   = (state == frame_end);

    ////////////////////
    // Sequencer control.
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= init_ring;
            slot_idx   <= '0;
            rd_start   <= '0;
            row        <= '0;
            grp        <= '0;
            row_base   <= PLOT_FIRST;
            rd_req     <= 1'b0;
            wr_req     <= 1'b0;
            frame_done <= 1'b0;
        end else if (!en) begin
            state      <= init_ring; // Redo init on re-enable.
            slot_idx   <= '0;
            rd_start   <= '0;
            row        <= '0;
            grp        <= '0;
            row_base   <= PLOT_FIRST;
            rd_req     <= 1'b0;
            wr_req     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                init_ring: begin
                    if (wr_done) begin
                        wr_req <= 1'b0;
                        if (slot_idx == LAST_SLOT) state <= clear_plot;
                        slot_idx <= next_slot(slot_idx);
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                clear_plot: begin
                    if (wr_done) begin
                        wr_req <= 1'b0;
                        if (grp == LAST_GRP) begin
                            grp <= '0;
                            if (row == LAST_SLOT) begin
                                row      <= '0;
                                row_base <= PLOT_FIRST;
                                state    <= idle;
                            end else begin
                                row      <= row + 1'b1;
                                row_base <= row_base + sdram_addr_t'(LINE_STRIDE);
                            end
                        end else begin
                            grp <= grp + 1'b1;
                        end
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                idle: if (link.pending) state <= advance;
                advance: begin
                    // New sample goes just before the new read start.
                    slot_idx <= rd_start;
                    rd_start <= next_slot(rd_start);
                    state    <= write_new;
                end
                write_new: begin
                    if (wr_done) begin
                        wr_req   <= 1'b0;
                        slot_idx <= rd_start; // Oldest first.
                        row      <= '0;
                        row_base <= PLOT_FIRST;
                        state    <= read_slot;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                read_slot: begin
                    if (rd_done) begin
                        rd_req <= 1'b0;
                        grp    <= '0;
                        state  <= paint_group;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end
                paint_group: begin
                    if (wr_done) begin
                        wr_req <= 1'b0;
                        if (grp == LAST_GRP) state <= next_row;
                        else grp <= grp + 1'b1;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                next_row: begin
                    if (row == LAST_SLOT) begin
                        state <= frame_end;
                    end else begin
                        row      <= row + 1'b1;
                        row_base <= row_base + sdram_addr_t'(LINE_STRIDE);
                        slot_idx <= next_slot(slot_idx);
                        state    <= read_slot;
                    end
                end
                frame_end: begin
                    frame_done <= 1'b1; // Lines up with extrema update.
                    state      <= idle;
                end
                default: state <= init_ring;
            endcase
        end
    end

    ////////////////////
    // Address and data.
    ////////////////////
    always_ff @(posedge clk) begin
        case (state)
            init_ring: begin
                wr_addr <= slot_addr(slot_idx);
                wr_data <= '0;
            end
            clear_plot: begin
                wr_addr <= grp_addr;
                wr_data <= {burst_words_c{color_bg_c}};
            end
            idle: begin
                if (link.pending) begin // Snapshot, later samples may land.
                    wr_data[0]  <= link.pulse_count;
                    wr_data[1]  <= {8'h00, link.disp_count[23:16]}; // High byte.
                    wr_data[2]  <= {8'h00, link.disp_count[15:8]};
                    wr_data[3]  <= {8'h00, link.disp_count[7:0]};
                    frame_shift <= link.shift;
                end
            end
            write_new: wr_addr <= slot_addr(slot_idx);
            read_slot: begin
                rd_addr <= slot_addr(slot_idx);
                if (rd_done) begin
                    bar_len <= (scaled_len > 16'(PLOT_WIDTH)) ? 16'(PLOT_WIDTH) : scaled_len;
                end
            end
            paint_group: begin
                wr_addr <= grp_addr;
                if (grp_end <= {1'b0, bar_len}) wr_data <= {burst_words_c{color_bar_c}};
                else wr_data <= {burst_words_c{color_bg_c}};
            end
            default: ;
        endcase
    end

    // One SDRAM port active at a time.
    no_dual_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_req && wr_req));

    // Writes only touch the ring or the plot area.
    wr_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> ((wr_addr >= RING_FIRST && wr_addr <= RING_LAST) ||
                    (wr_addr >= PLOT_FIRST && wr_addr <= PLOT_LAST)));

endmodule

`default_nettype wire

/* src/sample_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_decode import plot_geom_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        pause,        // High freezes the chart.
    input  logic        sample_valid,
    input  logic [15:0] sample,
    input  logic [23:0] disp_count,
    input  logic [7:0]  gain_code,
    plot_link_if.sample link
);

    gain_shift_t shift_dec;
    logic        accept;

    // Gain code to shift amount.
    always_comb begin
        case (gain_code)
            gain_div2: shift_dec = 2'd1;
            gain_div4: shift_dec = 2'd2;
            gain_div8: shift_dec = 2'd3;
            default:   shift_dec = 2'd0; // Full scale.
        endcase
    end

    assign accept = sample_valid && !pause && en;

    // Pending flag. A new sample beats a take in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link.pending <= 1'b0;
        end else if (!en) begin
            link.pending <= 1'b0;
        end else if (accept) begin
            link.pending <= 1'b1;
        end else if (link.take) begin
            link.pending <= 1'b0;
        end
    end

    // Latest sample wins.
    always_ff @(posedge clk) begin
        if (accept) begin
            link.pulse_count <= sample;
            link.disp_count  <= disp_count;
            link.shift       <= shift_dec; // Gain travels with its sample.
        end
    end

endmodule

`default_nettype wire

/* src/plot_link_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Sample hand-off from intake to the sequencer, and the value stream
// from the sequencer to the extrema block. Instantiated once per link.
interface plot_link_if import plot_geom_pkg::*; ();

    ////////////////////
    // Sample link.
    ////////////////////
    logic        pending;     // Unconsumed sample held.
    logic [15:0] pulse_count; // Latched pulse count.
    logic [23:0] disp_count;  // Latched display count.
    gain_shift_t shift;       // Bar scaling.
    logic        take;        // Sequencer consumed it.

    ////////////////////
    // Extrema link.
    ////////////////////
    logic        frame_start; // Clear accumulators.
    logic        value_valid; // One slot read back.
    logic [23:0] value;       // Its display count.
    logic        frame_end;   // Publish result.

    modport sample (output pending, pulse_count, disp_count, shift, input take);
    modport exec   (input pending, pulse_count, disp_count, shift, output take);

    modport extrema (output frame_start, value_valid, value, frame_end);
    modport result  (input frame_start, value_valid, value, frame_end);

endinterface

`default_nettype wire

/* src/sdram_cmd_pkg.sv */
`default_nettype none

package sdram_cmd_pkg;

    // Bank, row and column packed into one word address.
    typedef logic [23:0] sdram_addr_t;

    // One burst of four words.
    // Word 1 sits in element 0, word 4 in element 3.
    typedef logic [3:0][15:0] burst_t;

    ////////////////////
    // Draw sequencer states.
    ////////////////////
    typedef enum logic [3:0] {
        init_ring,   // Zero every ring slot.
        clear_plot,  // Paint plot background.
        idle,        // Wait for a sample.
        advance,     // Step the read start.
        write_new,   // Store new sample.
        read_slot,   // Fetch one ring slot.
        paint_group, // Write one group of a row.
        next_row,    // Step to next row and slot.
        frame_end    // Publish extrema.
    } draw_state_e;

endpackage

`default_nettype wire

/* src/plot_geom_pkg.sv */
`default_nettype none

package plot_geom_pkg;

    ////////////////////
    // Burst geometry.
    ////////////////////
    localparam int burst_words_c = 4; // Words moved per SDRAM access.

    ////////////////////
    // RGB565 colours.
    ////////////////////
    localparam logic [15:0] color_bar_c = 16'hF81F; // Pink bar.
    localparam logic [15:0] color_bg_c  = 16'h0000; // Black background.

    // Gain codes from the front panel.
    // Anything else means no division.
    typedef enum logic [7:0] {
        gain_div2 = 8'd2, // Right shift by 1.
        gain_div4 = 8'd3, // Right shift by 2.
        gain_div8 = 8'd4  // Right shift by 3.
    } gain_code_e;

    typedef logic [1:0] gain_shift_t; // Decoded shift, 0 to 3.

endpackage

`default_nettype wire
